/* common/conv1_pkg.sv */
package conv1_pkg;

    // frame geometry
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HIGH   = 8;
    localparam int PAD_WIDTH  = IMG_WIDTH + 2;
    localparam int PAD_HIGH   = IMG_HIGH + 2;

    // kernel and channel counts
    localparam int PE_ROW     = 3;
    localparam int PE_COL     = 3;
    localparam int PE_NUM     = 3;
    localparam int OUT_CHNNLS = 4;

    // arithmetic widths
    localparam int QUAN_BITS        = 8;
    localparam int DATA_WIDTH       = 64;
    localparam int ACC_BITS         = 22;
    localparam int WEIGHT_SCALE     = 4;
    localparam int WORDS_PER_KERNEL = 2;
    localparam int KERNEL_BITS      = PE_ROW * PE_COL * QUAN_BITS;

    // partial sums wait this many pixel steps between kernel rows
    localparam int LINE_DELAY = PAD_WIDTH - PE_COL;

    typedef logic signed [QUAN_BITS-1:0]  quan_t;
    typedef logic        [DATA_WIDTH-1:0] weight_word_t;
    typedef logic signed [ACC_BITS-1:0]   acc_t;
    typedef logic        [3:0]            pos_t;
    typedef logic        [1:0]            chnl_t;

    typedef struct packed {
        quan_t ch0;
        quan_t ch1;
        quan_t ch2;
    } pixel_t;

    typedef struct packed {
        chnl_t chnl;
        pos_t  row;
        pos_t  col;
        acc_t  data;
    } out_wr_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD_WEIGHTS,
        S_CAL,
        S_DONE
    } conv1_state_t;

    // one bias per output channel, scaled up by WEIGHT_SCALE before the add
    localparam quan_t CONV1_BIAS [OUT_CHNNLS] = '{
        8'sd6,
        -8'sd9,
        8'sd17,
        -8'sd3
    };

endpackage

/* conv_layer1/conv_mac_unit.sv */
`timescale 1ns/1ps

module conv_mac_unit
    import conv1_pkg::*;
(
    input  logic  s_clk,
    input  logic  s_rst,
    input  logic  i_weight_load,
    input  quan_t i_weight,
    input  logic  i_feature_valid,
    input  quan_t i_feature,
    input  acc_t  i_shift_in,
    output logic  o_valid,
    output acc_t  o_sum
);

    quan_t                         r_weight;
    logic signed [2*QUAN_BITS-1:0] r_prod;
    logic                          r_prod_valid;

    // stage one, product of pixel and stored weight
    always_ff @(posedge s_clk) begin
        if (i_weight_load) begin
            r_weight <= i_weight;
        end
        if (i_feature_valid) begin
            r_prod <= r_weight * i_feature;
        end
    end

    // stage two, add the neighbour's partial sum
    // o_sum holds across gaps until the next pixel step
    always_ff @(posedge s_clk) begin
        if (r_prod_valid) begin
            o_sum <= acc_t'(r_prod) + i_shift_in;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_prod_valid <= 1'b0;
            o_valid      <= 1'b0;
        end else begin
            r_prod_valid <= i_feature_valid;
            o_valid      <= r_prod_valid;
        end
    end

endmodule

/* conv_layer1/conv_line_buffer.sv */
`timescale 1ns/1ps

module conv_line_buffer
    import conv1_pkg::*;
(
    input  logic s_clk,
    input  logic s_rst,
    input  logic i_en,
    input  acc_t i_data,
    output acc_t o_data
);

    acc_t r_taps [LINE_DELAY];

    // moves only on a pixel step, so the output holds across gaps
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int i = 0; i < LINE_DELAY; i++) begin
                r_taps[i] <= '0;
            end
        end else if (i_en) begin
            r_taps[0] <= i_data;
            for (int i = 1; i < LINE_DELAY; i++) begin
                r_taps[i] <= r_taps[i-1];
            end
        end
    end

    assign o_data = r_taps[LINE_DELAY-1];

endmodule

/* conv_layer1/conv_pe_array.sv */
`timescale 1ns/1ps

module conv_pe_array
    import conv1_pkg::*;
(
    input  logic                   s_clk,
    input  logic                   s_rst,
    input  logic                   i_weight_load,
    input  logic [KERNEL_BITS-1:0] i_kernel,
    input  logic                   i_feature_valid,
    input  quan_t                  i_feature,
    output logic                   o_valid,
    output acc_t                   o_sum
);

    acc_t                      mac_sum [PE_ROW][PE_COL];
    acc_t                      mac_in  [PE_ROW][PE_COL];
    logic [PE_ROW*PE_COL-1:0]  mac_valid;
    acc_t                      lb_out  [PE_ROW-1];
    logic                      r_step;

    // pixel step strobe, lines up with stage two of every unit
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_step <= 1'b0;
        end else begin
            r_step <= i_feature_valid;
        end
    end

    for (genvar r = 0; r < PE_ROW; r++) begin : g_row
        for (genvar c = 0; c < PE_COL; c++) begin : g_col
            if (c > 0) begin : g_left
                assign mac_in[r][c] = mac_sum[r][c-1];
            end else if (r > 0) begin : g_line
                assign mac_in[r][c] = lb_out[r-1];
            end else begin : g_first
                assign mac_in[r][c] = '0;
            end

            conv_mac_unit u_mac (
                .s_clk           (s_clk),
                .s_rst           (s_rst),
                .i_weight_load   (i_weight_load),
                .i_weight        (i_kernel[(r*PE_COL+c)*QUAN_BITS +: QUAN_BITS]),
                .i_feature_valid (i_feature_valid),
                .i_feature       (i_feature),
                .i_shift_in      (mac_in[r][c]),
                .o_valid         (mac_valid[r*PE_COL+c]),
                .o_sum           (mac_sum[r][c])
            );
        end
    end

    // row end to next row start, LINE_DELAY steps here plus one unit hop
    for (genvar r = 0; r < PE_ROW-1; r++) begin : g_lb
        conv_line_buffer u_lb (
            .s_clk  (s_clk),
            .s_rst  (s_rst),
            .i_en   (r_step),
            .i_data (mac_sum[r][PE_COL-1]),
            .o_data (lb_out[r])
        );
    end

    // all nine units run in lockstep
    assign o_valid = &mac_valid;
    assign o_sum   = mac_sum[PE_ROW-1][PE_COL-1];

endmodule

/* conv_layer1/conv_layer1.sv */
`timescale 1ns/1ps

module conv_layer1
    import conv1_pkg::*;
(
    input  logic         s_clk,
    input  logic         s_rst,
    input  logic         i_network_cal_done,
    input  weight_word_t i_weight,
    input  logic         i_weight_valid,
    output logic         o_weight_ready,
    input  pixel_t       i_pixel,
    input  logic         i_pixel_valid,
    output logic         o_data_ready,
    output logic         o_load_d_once_done,
    output logic         o_load_finish,
    output acc_t         o_conv1_out,
    output logic         o_conv1_out_valid
);

    conv1_state_t           r_state;
    conv1_state_t           w_next;
    logic [2:0]             r_wcnt;
    logic                   r_wload_done;
    weight_word_t           r_wlow;
    logic [KERNEL_BITS-1:0] r_kernel;
    logic [PE_NUM-1:0]      r_kstrobe;
    pos_t                   r_px;
    pos_t                   r_py;
    logic                   r_pix_done;
    logic [2:0]             r_drain;
    chnl_t                  r_chnl;
    pos_t                   r_ox;
    pos_t                   r_oy;
    acc_t                   r_csum;
    logic                   r_csum_valid;
    quan_t                  w_feat    [PE_NUM];
    acc_t                   w_arr_sum [PE_NUM];
    logic [PE_NUM-1:0]      w_arr_valid;
    logic                   w_wacc;
    logic                   w_wlast;
    logic                   w_pacc;
    logic                   w_plast;
    logic                   w_out_step;
    logic                   w_win_ok;
    acc_t                   w_bias;

    assign w_wacc     = i_weight_valid && o_weight_ready;
    assign w_wlast    = w_wacc && (r_wcnt == WORDS_PER_KERNEL*PE_NUM-1);
    assign w_pacc     = i_pixel_valid && o_data_ready;
    assign w_plast    = w_pacc && (r_px == PAD_WIDTH-1) && (r_py == PAD_HIGH-1);
    assign w_out_step = &w_arr_valid;
    assign w_win_ok   = (r_oy >= PE_ROW-1) && (r_ox >= PE_COL-1);
    assign w_bias     = acc_t'(CONV1_BIAS[r_chnl]) <<< WEIGHT_SCALE;

    assign o_load_finish = (r_state == S_DONE);

    always_comb begin
        w_next = r_state;
        case (r_state)
            S_IDLE:         w_next = S_LOAD_WEIGHTS;
            S_LOAD_WEIGHTS: if (r_wload_done) w_next = S_CAL;
            // leave only once the pipeline has drained
            S_CAL:          if (r_drain[2]) w_next = (r_chnl == OUT_CHNNLS-1) ? S_DONE : S_IDLE;
            S_DONE:         if (i_network_cal_done) w_next = S_IDLE;
            default:        w_next = S_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_state            <= S_IDLE;
            r_wcnt             <= '0;
            r_wload_done       <= 1'b0;
            r_kstrobe          <= '0;
            o_weight_ready     <= 1'b0;
            r_px               <= '0;
            r_py               <= '0;
            r_pix_done         <= 1'b0;
            o_data_ready       <= 1'b0;
            o_load_d_once_done <= 1'b0;
            r_drain            <= '0;
            r_chnl             <= '0;
        end else begin
            r_state <= w_next;

            // six words per channel, every second one completes a kernel
            if (w_wacc) begin
                r_wcnt <= w_wlast ? 3'd0 : r_wcnt + 1'b1;
            end
            if (w_wlast) begin
                r_wload_done <= 1'b1;
            end else if (r_state != S_LOAD_WEIGHTS) begin
                r_wload_done <= 1'b0;
            end
            if (w_wacc && r_wcnt[0]) begin
                r_kstrobe <= {{(PE_NUM-1){1'b0}}, 1'b1} << r_wcnt[2:1];
            end else begin
                r_kstrobe <= '0;
            end
            o_weight_ready <= (r_state == S_LOAD_WEIGHTS) && !r_wload_done && !w_wlast;

            if (w_pacc) begin
                r_px <= (r_px == PAD_WIDTH-1) ? '0 : r_px + 1'b1;
                if (r_px == PAD_WIDTH-1) begin
                    r_py <= (r_py == PAD_HIGH-1) ? '0 : r_py + 1'b1;
                end
            end
            if (w_plast) begin
                r_pix_done <= 1'b1;
            end else if (r_state == S_IDLE) begin
                r_pix_done <= 1'b0;
            end
            o_data_ready       <= (r_state == S_CAL) && !r_pix_done && !w_plast;
            o_load_d_once_done <= w_plast;
            r_drain            <= {r_drain[1:0], o_load_d_once_done};

            // wraps to channel 0 for the next frame
            if (r_drain[2]) begin
                r_chnl <= r_chnl + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (w_wacc && !r_wcnt[0]) begin
            r_wlow <= i_weight;
        end
        if (w_wacc && r_wcnt[0]) begin
            r_kernel <= {i_weight[KERNEL_BITS-DATA_WIDTH-1:0], r_wlow};
        end
    end

    assign w_feat[0] = i_pixel.ch0;
    assign w_feat[1] = i_pixel.ch1;
    assign w_feat[2] = i_pixel.ch2;

    for (genvar k = 0; k < PE_NUM; k++) begin : g_arr
        conv_pe_array u_arr (
            .s_clk           (s_clk),
            .s_rst           (s_rst),
            .i_weight_load   (r_kstrobe[k]),
            .i_kernel        (r_kernel),
            .i_feature_valid (w_pacc),
            .i_feature       (w_feat[k]),
            .o_valid         (w_arr_valid[k]),
            .o_sum           (w_arr_sum[k])
        );
    end

    // padded position of the window's bottom-right pixel at the array output
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_ox              <= '0;
            r_oy              <= '0;
            r_csum_valid      <= 1'b0;
            o_conv1_out_valid <= 1'b0;
        end else begin
            if (w_out_step) begin
                r_ox <= (r_ox == PAD_WIDTH-1) ? '0 : r_ox + 1'b1;
                if (r_ox == PAD_WIDTH-1) begin
                    r_oy <= (r_oy == PAD_HIGH-1) ? '0 : r_oy + 1'b1;
                end
            end
            r_csum_valid      <= w_out_step && w_win_ok;
            o_conv1_out_valid <= r_csum_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (w_out_step) begin
            r_csum <= w_arr_sum[0] + w_arr_sum[1] + w_arr_sum[2];
        end
        o_conv1_out <= r_csum + w_bias;
    end

    a_weight_in_load: assert property (@(posedge s_clk) disable iff (s_rst)
        w_wacc |-> r_state == S_LOAD_WEIGHTS);

    a_no_out_in_idle: assert property (@(posedge s_clk) disable iff (s_rst)
        r_state == S_IDLE |-> !o_conv1_out_valid);

    a_one_kernel_strobe: assert property (@(posedge s_clk) disable iff (s_rst)
        $onehot0(r_kstrobe));

endmodule

/* verilog/conv1_out_writer.sv */
`timescale 1ns/1ps

module conv1_out_writer
    import conv1_pkg::*;
(
    input  logic    s_clk,
    input  logic    s_rst,
    input  acc_t    i_data,
    input  logic    i_valid,
    output out_wr_t o_wr,
    output logic    o_wr_valid,
    output logic    o_frame_done
);

    pos_t       r_col;
    pos_t       r_row;
    chnl_t      r_chnl;
    logic [6:0] r_seen;
    logic       w_chnl_last;

    assign w_chnl_last = (r_col == IMG_WIDTH-1) && (r_row == IMG_HIGH-1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_col        <= '0;
            r_row        <= '0;
            r_chnl       <= '0;
            r_seen       <= '0;
            o_wr_valid   <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_wr_valid   <= i_valid;
            o_frame_done <= i_valid && w_chnl_last && (r_chnl == OUT_CHNNLS-1);
            if (i_valid) begin
                r_col  <= (r_col == IMG_WIDTH-1) ? '0 : r_col + 1'b1;
                r_seen <= w_chnl_last ? '0 : r_seen + 1'b1;
                if (r_col == IMG_WIDTH-1) begin
                    r_row <= (r_row == IMG_HIGH-1) ? '0 : r_row + 1'b1;
                end
                if (w_chnl_last) begin
                    r_chnl <= r_chnl + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_valid) begin
            o_wr <= '{chnl: r_chnl, row: r_row, col: r_col, data: i_data};
        end
    end

    a_chnl_results: assert property (@(posedge s_clk) disable iff (s_rst)
        i_valid |-> r_seen < IMG_WIDTH*IMG_HIGH);

endmodule

/* verilog/conv1_top.sv */
`timescale 1ns/1ps

module conv1_top
    import conv1_pkg::*;
(
    input  logic         s_clk,
    input  logic         s_rst,
    input  weight_word_t i_weight,
    input  logic         i_weight_valid,
    input  pixel_t       i_pixel,
    input  logic         i_pixel_valid,
    input  logic         i_network_cal_done,
    output logic         o_weight_ready,
    output logic         o_data_ready,
    output logic         o_load_d_once_done,
    output logic         o_load_finish,
    output out_wr_t      o_wr,
    output logic         o_wr_valid,
    output logic         o_frame_done
);

    acc_t conv1_out;
    logic conv1_out_valid;

    conv_layer1 u_conv_layer1 (
        .s_clk              (s_clk),
        .s_rst              (s_rst),
        .i_network_cal_done (i_network_cal_done),
        .i_weight           (i_weight),
        .i_weight_valid     (i_weight_valid),
        .o_weight_ready     (o_weight_ready),
        .i_pixel            (i_pixel),
        .i_pixel_valid      (i_pixel_valid),
        .o_data_ready       (o_data_ready),
        .o_load_d_once_done (o_load_d_once_done),
        .o_load_finish      (o_load_finish),
        .o_conv1_out        (conv1_out),
        .o_conv1_out_valid  (conv1_out_valid)
    );

    conv1_out_writer u_out_writer (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_data       (conv1_out),
        .i_valid      (conv1_out_valid),
        .o_wr         (o_wr),
        .o_wr_valid   (o_wr_valid),
        .o_frame_done (o_frame_done)
    );

endmodule

/* sim/conv1_ref.svh */
`ifndef CONV1_REF_SVH
`define CONV1_REF_SVH

// img and kern are declared by the including testbench

// padded frame value, zero on the one-pixel border
function automatic int padded_value(input int c, input int py, input int px);
    if (py < 1 || py > IMG_HIGH || px < 1 || px > IMG_WIDTH) begin
        return 0;
    end
    return int'(img[c][py-1][px-1]);
endfunction

function automatic pixel_t build_padded_pixel(input int py, input int px);
    pixel_t p;
    p.ch0 = quan_t'(padded_value(0, py, px));
    p.ch1 = quan_t'(padded_value(1, py, px));
    p.ch2 = quan_t'(padded_value(2, py, px));
    return p;
endfunction

// words 0,1 hold input channel 0, words 2,3 channel 1, words 4,5 channel 2
function automatic weight_word_t pack_kernel_word(input int oc, input int idx);
    logic [KERNEL_BITS-1:0] kbits;
    int                     c;
    c     = idx / WORDS_PER_KERNEL;
    kbits = '0;
    for (int ky = 0; ky < PE_ROW; ky++) begin
        for (int kx = 0; kx < PE_COL; kx++) begin
            kbits[(ky*PE_COL+kx)*QUAN_BITS +: QUAN_BITS] = kern[oc][c][ky][kx];
        end
    end
    if (idx % WORDS_PER_KERNEL == 0) begin
        return kbits[DATA_WIDTH-1:0];
    end else begin
        return weight_word_t'(kbits >> DATA_WIDTH);
    end
endfunction

// window top-left sits at padded (y, x) for output (y, x)
function automatic int expected_result(input int oc, input int y, input int x);
    int acc;
    acc = int'(CONV1_BIAS[oc]) * (2 ** WEIGHT_SCALE);
    for (int c = 0; c < PE_NUM; c++) begin
        for (int ky = 0; ky < PE_ROW; ky++) begin
            for (int kx = 0; kx < PE_COL; kx++) begin
                acc += int'(kern[oc][c][ky][kx]) * padded_value(c, y + ky, x + kx);
            end
        end
    end
    return acc;
endfunction

`endif

/* sim/tb_conv1_top.sv */
`timescale 1ns/1ps

module tb_conv1_top
    import conv1_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_FRAMES   = 3;
    // six words, 100 pixels with gaps and the drain fit well inside this
    localparam int CHNL_CYCLES  = 300;
    localparam int PIXELS       = PAD_WIDTH * PAD_HIGH;
    localparam int RESULTS      = OUT_CHNNLS * IMG_WIDTH * IMG_HIGH;

    logic         s_clk;
    logic         s_rst;
    weight_word_t i_weight;
    logic         i_weight_valid;
    pixel_t       i_pixel;
    logic         i_pixel_valid;
    logic         i_network_cal_done;
    logic         o_weight_ready;
    logic         o_data_ready;
    logic         o_load_d_once_done;
    logic         o_load_finish;
    out_wr_t      o_wr;
    logic         o_wr_valid;
    logic         o_frame_done;

    quan_t img       [PE_NUM][IMG_HIGH][IMG_WIDTH];
    quan_t kern      [OUT_CHNNLS][PE_NUM][PE_ROW][PE_COL];
    int    first_res [OUT_CHNNLS][IMG_HIGH][IMG_WIDTH];
    int    seed        = 84;
    string test_name   = "reset";
    int    res_count   = 0;
    int    done_pulses = 0;
    int    exp_col     = 0;
    int    exp_row     = 0;
    int    exp_ch      = 0;

    `include "conv1_ref.svh"

    conv1_top dut0 (
        .s_clk              (s_clk),
        .s_rst              (s_rst),
        .i_weight           (i_weight),
        .i_weight_valid     (i_weight_valid),
        .i_pixel            (i_pixel),
        .i_pixel_valid      (i_pixel_valid),
        .i_network_cal_done (i_network_cal_done),
        .o_weight_ready     (o_weight_ready),
        .o_data_ready       (o_data_ready),
        .o_load_d_once_done (o_load_d_once_done),
        .o_load_finish      (o_load_finish),
        .o_wr               (o_wr),
        .o_wr_valid         (o_wr_valid),
        .o_frame_done       (o_frame_done)
    );

    initial begin
        s_clk = 1'b0;
        forever #(CLK_PERIOD/2) s_clk = ~s_clk;
    end

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("error %s %s: expected %0d actual %0d", test_name, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic fill_random_frame();
        for (int c = 0; c < PE_NUM; c++) begin
            for (int y = 0; y < IMG_HIGH; y++) begin
                for (int x = 0; x < IMG_WIDTH; x++) begin
                    img[c][y][x] = quan_t'($random(seed));
                end
            end
        end
        for (int oc = 0; oc < OUT_CHNNLS; oc++) begin
            for (int c = 0; c < PE_NUM; c++) begin
                for (int k = 0; k < PE_ROW*PE_COL; k++) begin
                    kern[oc][c][k/PE_COL][k%PE_COL] = quan_t'($random(seed));
                end
            end
        end
    endtask

    task automatic send_weights(input int oc, input bit gaps);
        int idx;
        idx = 0;
        while (idx < WORDS_PER_KERNEL*PE_NUM) begin
            i_weight       <= pack_kernel_word(oc, idx);
            i_weight_valid <= !(gaps && (($random(seed) & 3) == 0));
            @(posedge s_clk);
            if (i_weight_valid && o_weight_ready) begin
                idx++;
            end
        end
        i_weight_valid <= 1'b0;
        @(posedge s_clk);
        check_value("weight ready after six words", 0, o_weight_ready);
    endtask

    task automatic send_pixels(input bit gaps);
        int idx;
        idx = 0;
        while (idx < PIXELS) begin
            i_pixel       <= build_padded_pixel(idx / PAD_WIDTH, idx % PAD_WIDTH);
            i_pixel_valid <= !(gaps && (($random(seed) & 3) == 0));
            @(posedge s_clk);
            if (i_pixel_valid && o_data_ready) begin
                idx++;
            end
        end
        i_pixel_valid <= 1'b0;
    endtask

    task automatic run_frame(input int frame, input bit gaps);
        for (int oc = 0; oc < OUT_CHNNLS; oc++) begin
            send_weights(oc, gaps);
            send_pixels(gaps);
        end
        while (!o_load_finish) begin
            @(posedge s_clk);
        end
        // layer parked in S_DONE until the network strobe
        repeat (20) begin
            @(posedge s_clk);
            check_value("load finish held", 1, o_load_finish);
            check_value("weight ready in done", 0, o_weight_ready);
            check_value("data ready in done", 0, o_data_ready);
        end
        check_value("result count", (frame + 1) * RESULTS, res_count);
        check_value("pass done pulses", (frame + 1) * OUT_CHNNLS, done_pulses);
        i_network_cal_done <= 1'b1;
        @(posedge s_clk);
        i_network_cal_done <= 1'b0;
    endtask

    always @(posedge s_clk) begin
        if (!s_rst && o_load_d_once_done) begin
            done_pulses++;
        end
    end

    // compare every write against the reference, raster order included
    always @(posedge s_clk) begin
        if (!s_rst && o_wr_valid) begin
            check_value("write channel", exp_ch, o_wr.chnl);
            check_value("write row", exp_row, o_wr.row);
            check_value("write column", exp_col, o_wr.col);
            check_value("result data", expected_result(o_wr.chnl, o_wr.row, o_wr.col),
                        o_wr.data);
            check_value("frame done on last result",
                        exp_ch == OUT_CHNNLS-1 && exp_row == IMG_HIGH-1 &&
                        exp_col == IMG_WIDTH-1, o_frame_done);
            if (res_count / RESULTS == 0) begin
                first_res[exp_ch][exp_row][exp_col] = o_wr.data;
            end else if (res_count / RESULTS == 1) begin
                check_value("same as gapless frame", first_res[exp_ch][exp_row][exp_col],
                            o_wr.data);
            end
            res_count++;
            exp_col = (exp_col + 1) % IMG_WIDTH;
            if (exp_col == 0) begin
                exp_row = (exp_row + 1) % IMG_HIGH;
                if (exp_row == 0) begin
                    exp_ch = (exp_ch + 1) % OUT_CHNNLS;
                end
            end
        end else if (!s_rst) begin
            check_value("frame done without result", 0, o_frame_done);
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_FRAMES * OUT_CHNNLS * CHNL_CYCLES) @(posedge s_clk);
        $display("timeout: the layer stopped producing results before all frames finished");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        s_rst              = 1'b1;
        i_weight           = '0;
        i_weight_valid     = 1'b0;
        i_pixel            = '0;
        i_pixel_valid      = 1'b0;
        i_network_cal_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_clk);
        s_rst <= 1'b0;
        @(posedge s_clk);
        check_value("weight ready", 0, o_weight_ready);
        check_value("data ready", 0, o_data_ready);
        check_value("pass done", 0, o_load_d_once_done);
        check_value("load finish", 0, o_load_finish);
        check_value("write valid", 0, o_wr_valid);
        check_value("frame done", 0, o_frame_done);

        test_name = "gapless frame";
        fill_random_frame();
        run_frame(0, 1'b0);

        test_name = "gapped frame same data";
        run_frame(1, 1'b1);

        test_name = "new frame after network done";
        fill_random_frame();
        run_frame(2, 1'b1);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+sim
common/conv1_pkg.sv
conv_layer1/conv_mac_unit.sv
conv_layer1/conv_line_buffer.sv
conv_layer1/conv_pe_array.sv
conv_layer1/conv_layer1.sv
verilog/conv1_out_writer.sv
verilog/conv1_top.sv
sim/tb_conv1_top.sv
